/* Bender.yml */
package:
  name: membus2csr_adapter

sources:
  - files:
      - csr_adapter_pkg.sv
      - response_info_fifo.sv
      - membus_request_splitter.sv
      - csr_response_assembler.sv
      - membus2csr_adapter.sv
  - target: test
    files:
      - tb_membus2csr_adapter.sv

/* adapter_patterns.txt */
# cmd(0 rd,1 wr,2 wr_np) addr len id force base be0 be1 be2 be3 exp0 exp1 exp2 exp3
# Write unit at beat b, slot s is base+4*b+s; exp0..exp3 are slots 0..3 of the first read beat
2 0000 2 1 0 11110000 FFFF FFFF 0000 0000 00000000 00000000 00000000 00000000
0 0000 2 2 0 00000000 0000 0000 0000 0000 11110000 11110001 11110002 11110003
0 0008 1 3 0 00000000 0000 0000 0000 0000 00000000 00000000 11110002 11110003
1 0020 1 4 0 22220000 0F0F 0000 0000 0000 00000000 00000000 00000000 00000000
0 0020 1 5 0 00000000 0000 0000 0000 0000 22220000 DEAD0024 22220002 DEAD002C
2 0030 1 6 0 33330000 FFFF 0000 0000 0000 00000000 00000000 00000000 00000000
2 0030 1 7 0 44440000 F00F 0000 0000 0000 00000000 00000000 00000000 00000000
0 0030 1 8 0 00000000 0000 0000 0000 0000 44440000 33330001 33330002 44440003
1 0040 1 9 1 55550000 FFFF 0000 0000 0000 00000000 00000000 00000000 00000000
0 0044 1 A 0 00000000 0000 0000 0000 0000 00000000 55550001 55550002 55550003
0 00E0 2 B 0 00000000 0000 0000 0000 0000 DEAD00E0 DEAD00E4 DEAD00E8 DEAD00EC
2 00F8 1 C 0 66660000 FFFF 0000 0000 0000 00000000 00000000 00000000 00000000
2 0050 1 D 0 00000000 0000 0000 0000 0000 00000000 00000000 00000000 00000000
2 0060 1 1 0 77770000 FFFF 0000 0000 0000 00000000 00000000 00000000 00000000
2 0070 1 2 0 88880000 FFFF 0000 0000 0000 00000000 00000000 00000000 00000000
2 0080 1 3 0 99990000 FFFF 0000 0000 0000 00000000 00000000 00000000 00000000
0 0060 4 E 0 00000000 0000 0000 0000 0000 77770000 77770001 77770002 77770003
1 00A4 3 5 0 AAAA0000 FFFF FFFF FFFF 0000 00000000 00000000 00000000 00000000
0 00A0 3 6 0 00000000 0000 0000 0000 0000 DEAD00A0 AAAA0001 AAAA0002 AAAA0003
1 0090 1 7 1 BBBB0000 0000 0000 0000 0000 00000000 00000000 00000000 00000000

/* compile.f */
csr_adapter_pkg.sv
response_info_fifo.sv
membus_request_splitter.sv
csr_response_assembler.sv
membus2csr_adapter.sv
tb_membus2csr_adapter.sv

/* csr_adapter_pkg.sv */
package csr_adapter_pkg;

  //////////////////////////////
  // Bus geometry
  //////////////////////////////
  localparam int UNIT_WIDTH      = 32;
  localparam int UNIT_COUNT      = 4;
  localparam int MAX_BEATS       = 4;
  localparam int MAX_NP_REQUESTS = 2;
  localparam int UNIT_BYTES      = UNIT_WIDTH / 8;
  localparam int INDEX_LSB       = $clog2(UNIT_BYTES);
  localparam int NP_PTR_WIDTH    = $clog2(MAX_NP_REQUESTS);

  typedef logic [15:0]                            addr_t;
  typedef logic [UNIT_WIDTH*UNIT_COUNT-1:0]       beat_data_t;
  typedef logic [UNIT_BYTES*UNIT_COUNT-1:0]       byteen_t;
  typedef logic [UNIT_WIDTH-1:0]                  unit_data_t;
  typedef logic [3:0]                             id_t;
  typedef logic [$clog2(MAX_BEATS):0]             length_t;
  typedef logic [$clog2(UNIT_COUNT*MAX_BEATS):0]  unit_count_t;
  typedef logic [$clog2(UNIT_COUNT)-1:0]          unit_index_t;

  typedef enum logic [1:0] {
    CMD_READ     = 2'd0,
    CMD_WRITE    = 2'd1,
    CMD_WRITE_NP = 2'd2
  } cmd_e;

  //////////////////////////////
  // Response record layout
  //////////////////////////////
  // Bit 12 is_read, bit 11 ignore, id, start index, then the access count at the bottom
  localparam int INFO_COUNT_LSB   = 0;
  localparam int INFO_START_LSB   = INFO_COUNT_LSB + $bits(unit_count_t);
  localparam int INFO_ID_LSB      = INFO_START_LSB + $bits(unit_index_t);
  localparam int INFO_IGNORE_BIT  = INFO_ID_LSB + $bits(id_t);
  localparam int INFO_IS_READ_BIT = INFO_IGNORE_BIT + 1;
  localparam int INFO_WIDTH       = INFO_IS_READ_BIT + 1;

  typedef logic [INFO_WIDTH-1:0] resp_info_t;

endpackage

/* csr_response_assembler.sv */
`timescale 1ns/1ps

module csr_response_assembler (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  csr_adapter_pkg::resp_info_t i_info_head,
  input  logic                        i_info_empty,
  output logic                        o_info_pop,
  input  logic                        i_csr_sresp_valid,
  input  csr_adapter_pkg::unit_data_t i_csr_sdata,
  input  logic                        i_csr_serror,
  output logic                        o_csr_mresp_accept,
  output logic                        o_sresp_valid,
  output csr_adapter_pkg::id_t        o_sid,
  output csr_adapter_pkg::beat_data_t o_sdata,
  output logic                        o_serror,
  output logic                        o_sresp_last,
  input  logic                        i_sresp_accept
);

  logic                         head_read;
  logic                         head_ignore;
  csr_adapter_pkg::unit_index_t head_start;
  csr_adapter_pkg::unit_count_t head_count;
  csr_adapter_pkg::unit_count_t recv_q;
  csr_adapter_pkg::unit_index_t slot_q;
  csr_adapter_pkg::unit_data_t  data_q [csr_adapter_pkg::UNIT_COUNT];
  logic                         err_q;
  csr_adapter_pkg::unit_index_t cur_slot;
  csr_adapter_pkg::unit_index_t lo_slot;
  csr_adapter_pkg::beat_data_t  beat_word;
  logic                         all_received;
  logic                         resp_ack;
  logic                         last_resp;
  logic                         load_read;
  logic                         load_write;

  always_comb begin
    head_read   = i_info_head[csr_adapter_pkg::INFO_IS_READ_BIT];
    head_ignore = i_info_head[csr_adapter_pkg::INFO_IGNORE_BIT];
    head_start  = i_info_head[csr_adapter_pkg::INFO_START_LSB +:
                              $bits(csr_adapter_pkg::unit_index_t)];
    head_count  = i_info_head[csr_adapter_pkg::INFO_COUNT_LSB +:
                              $bits(csr_adapter_pkg::unit_count_t)];
    o_sid       = i_info_head[csr_adapter_pkg::INFO_ID_LSB +: $bits(csr_adapter_pkg::id_t)];

    all_received       = recv_q == head_count;
    o_csr_mresp_accept = !i_info_empty && !o_sresp_valid && !all_received;
    resp_ack           = i_csr_sresp_valid && o_csr_mresp_accept;
    last_resp          = (recv_q + csr_adapter_pkg::unit_count_t'(1)) == head_count;
    cur_slot           = (recv_q == '0) ? head_start : slot_q;

    // Only the first beat of a read begins above slot 0
    if ((recv_q + csr_adapter_pkg::unit_count_t'(head_start)) <
        csr_adapter_pkg::unit_count_t'(csr_adapter_pkg::UNIT_COUNT)) begin
      lo_slot = head_start;
    end else begin
      lo_slot = '0;
    end

    load_read  = resp_ack && head_read && ((cur_slot == '1) || last_resp);
    load_write = !i_info_empty && !head_read && !head_ignore && all_received &&
                 !o_sresp_valid;
    o_info_pop = (o_sresp_valid && i_sresp_accept && o_sresp_last) ||
                 (!i_info_empty && head_ignore && all_received);
  end

  //////////////////////////////
  // Beat assembly
  //////////////////////////////
  always_comb begin
    for (int i = 0; i < csr_adapter_pkg::UNIT_COUNT; i++) begin
      if (csr_adapter_pkg::unit_index_t'(i) == cur_slot) begin
        beat_word[csr_adapter_pkg::UNIT_WIDTH*i +: csr_adapter_pkg::UNIT_WIDTH] = i_csr_sdata;
      end else if ((csr_adapter_pkg::unit_index_t'(i) < cur_slot) &&
                   (csr_adapter_pkg::unit_index_t'(i) >= lo_slot)) begin
        beat_word[csr_adapter_pkg::UNIT_WIDTH*i +: csr_adapter_pkg::UNIT_WIDTH] = data_q[i];
      end else begin
        beat_word[csr_adapter_pkg::UNIT_WIDTH*i +: csr_adapter_pkg::UNIT_WIDTH] = '0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (resp_ack) begin
      data_q[cur_slot] <= i_csr_sdata;
    end
    if (load_read || load_write) begin
      o_sdata  <= load_write ? '0 : beat_word;
      o_serror <= load_write ? err_q : (err_q | i_csr_serror);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      recv_q <= '0;
      slot_q <= '0;
      err_q  <= 1'b0;
    end else begin
      if (o_info_pop) begin
        recv_q <= '0;
      end else if (resp_ack) begin
        recv_q <= recv_q + csr_adapter_pkg::unit_count_t'(1);
      end
      if (resp_ack) begin
        slot_q <= cur_slot + csr_adapter_pkg::unit_index_t'(1);
      end
      // Write errors gather over the whole burst, read errors per beat
      if (load_read || load_write || o_info_pop) begin
        err_q <= 1'b0;
      end else if (resp_ack) begin
        err_q <= err_q | i_csr_serror;
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_sresp_valid <= 1'b0;
      o_sresp_last  <= 1'b0;
    end else if (load_read || load_write) begin
      o_sresp_valid <= 1'b1;
      o_sresp_last  <= load_write || last_resp;
    end else if (o_sresp_valid && i_sresp_accept) begin
      o_sresp_valid <= 1'b0;
    end
  end

endmodule

/* membus2csr_adapter.sv */
`timescale 1ns/1ps

module membus2csr_adapter (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_force_np_write,
  input  logic                        i_mcmd_valid,
  input  csr_adapter_pkg::cmd_e       i_mcmd,
  input  csr_adapter_pkg::addr_t      i_maddr,
  input  csr_adapter_pkg::length_t    i_mlength,
  input  csr_adapter_pkg::id_t        i_mid,
  output logic                        o_mcmd_accept,
  input  logic                        i_mdata_valid,
  input  csr_adapter_pkg::beat_data_t i_mdata,
  input  csr_adapter_pkg::byteen_t    i_mdata_byteen,
  output logic                        o_mdata_accept,
  output logic                        o_sresp_valid,
  output csr_adapter_pkg::id_t        o_sid,
  output csr_adapter_pkg::beat_data_t o_sdata,
  output logic                        o_serror,
  output logic                        o_sresp_last,
  input  logic                        i_sresp_accept,
  output logic                        o_csr_mcmd_valid,
  output csr_adapter_pkg::cmd_e       o_csr_mcmd,
  output csr_adapter_pkg::addr_t      o_csr_maddr,
  output csr_adapter_pkg::unit_data_t o_csr_mdata,
  input  logic                        i_csr_scmd_accept,
  input  logic                        i_csr_sresp_valid,
  input  csr_adapter_pkg::unit_data_t i_csr_sdata,
  input  logic                        i_csr_serror,
  output logic                        o_csr_mresp_accept
);

  logic                        info_push;
  csr_adapter_pkg::resp_info_t info_data;
  logic                        info_full;
  logic                        info_pop;
  csr_adapter_pkg::resp_info_t info_head;
  logic                        info_empty;

  membus_request_splitter u_splitter (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_force_np_write  (i_force_np_write),
    .i_mcmd_valid      (i_mcmd_valid),
    .i_mcmd            (i_mcmd),
    .i_maddr           (i_maddr),
    .i_mlength         (i_mlength),
    .i_mid             (i_mid),
    .o_mcmd_accept     (o_mcmd_accept),
    .i_mdata_valid     (i_mdata_valid),
    .i_mdata           (i_mdata),
    .i_mdata_byteen    (i_mdata_byteen),
    .o_mdata_accept    (o_mdata_accept),
    .o_csr_mcmd_valid  (o_csr_mcmd_valid),
    .o_csr_mcmd        (o_csr_mcmd),
    .o_csr_maddr       (o_csr_maddr),
    .o_csr_mdata       (o_csr_mdata),
    .i_csr_scmd_accept (i_csr_scmd_accept),
    .i_info_full       (info_full),
    .o_info_push       (info_push),
    .o_info_data       (info_data)
  );

  response_info_fifo u_info_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (info_push),
    .i_data  (info_data),
    .i_pop   (info_pop),
    .o_data  (info_head),
    .o_empty (info_empty),
    .o_full  (info_full)
  );

  csr_response_assembler u_assembler (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_info_head        (info_head),
    .i_info_empty       (info_empty),
    .o_info_pop         (info_pop),
    .i_csr_sresp_valid  (i_csr_sresp_valid),
    .i_csr_sdata        (i_csr_sdata),
    .i_csr_serror       (i_csr_serror),
    .o_csr_mresp_accept (o_csr_mresp_accept),
    .o_sresp_valid      (o_sresp_valid),
    .o_sid              (o_sid),
    .o_sdata            (o_sdata),
    .o_serror           (o_serror),
    .o_sresp_last       (o_sresp_last),
    .i_sresp_accept     (i_sresp_accept)
  );

endmodule

/* membus_request_splitter.sv */
`timescale 1ns/1ps

module membus_request_splitter (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_force_np_write,
  input  logic                        i_mcmd_valid,
  input  csr_adapter_pkg::cmd_e       i_mcmd,
  input  csr_adapter_pkg::addr_t      i_maddr,
  input  csr_adapter_pkg::length_t    i_mlength,
  input  csr_adapter_pkg::id_t        i_mid,
  output logic                        o_mcmd_accept,
  input  logic                        i_mdata_valid,
  input  csr_adapter_pkg::beat_data_t i_mdata,
  input  csr_adapter_pkg::byteen_t    i_mdata_byteen,
  output logic                        o_mdata_accept,
  output logic                        o_csr_mcmd_valid,
  output csr_adapter_pkg::cmd_e       o_csr_mcmd,
  output csr_adapter_pkg::addr_t      o_csr_maddr,
  output csr_adapter_pkg::unit_data_t o_csr_mdata,
  input  logic                        i_csr_scmd_accept,
  input  logic                        i_info_full,
  output logic                        o_info_push,
  output csr_adapter_pkg::resp_info_t o_info_data
);

  logic                         busy;
  logic                         force_q;
  csr_adapter_pkg::unit_count_t remain_q;
  csr_adapter_pkg::unit_count_t issued_q;
  csr_adapter_pkg::unit_index_t index_q;
  csr_adapter_pkg::addr_t       addr_q;

  csr_adapter_pkg::unit_index_t start_index;
  csr_adapter_pkg::unit_index_t cur_index;
  csr_adapter_pkg::unit_count_t cur_remain;
  csr_adapter_pkg::unit_count_t cur_issued;
  csr_adapter_pkg::unit_count_t access_count;
  csr_adapter_pkg::addr_t       cur_addr;
  logic                         cur_force;
  logic                         is_write;
  logic                         is_non_posted;
  logic                         is_ignored;
  logic                         last_unit;
  logic                         unit_enabled;
  logic                         ready;
  logic                         advance;

  //////////////////////////////
  // Unit selection
  //////////////////////////////
  always_comb begin
    start_index = i_maddr[csr_adapter_pkg::INDEX_LSB +: $bits(csr_adapter_pkg::unit_index_t)];
    if (busy) begin
      cur_index  = index_q;
      cur_remain = remain_q;
      cur_issued = issued_q;
      cur_addr   = addr_q;
      cur_force  = force_q;
    end else begin
      // First unit of a burst comes straight from the presented command
      cur_index  = start_index;
      cur_remain = csr_adapter_pkg::unit_count_t'(i_mlength) *
                   csr_adapter_pkg::unit_count_t'(csr_adapter_pkg::UNIT_COUNT) -
                   csr_adapter_pkg::unit_count_t'(start_index);
      cur_issued = '0;
      cur_addr   = i_maddr & ~csr_adapter_pkg::addr_t'(csr_adapter_pkg::UNIT_BYTES - 1);
      cur_force  = i_force_np_write;
    end

    is_write      = i_mcmd != csr_adapter_pkg::CMD_READ;
    is_ignored    = (i_mcmd == csr_adapter_pkg::CMD_WRITE) && cur_force;
    is_non_posted = (i_mcmd != csr_adapter_pkg::CMD_WRITE) || cur_force;
    last_unit     = cur_remain == csr_adapter_pkg::unit_count_t'(1);
    unit_enabled  = !is_write ||
                    (i_mdata_byteen[csr_adapter_pkg::UNIT_BYTES*cur_index +:
                                    csr_adapter_pkg::UNIT_BYTES] != '0);

    // A new non-posted burst needs room for its record before it starts
    ready        = i_mcmd_valid && (!is_write || i_mdata_valid) &&
                   !(!busy && is_non_posted && i_info_full);
    advance      = ready && (!unit_enabled || i_csr_scmd_accept);
    access_count = cur_issued + csr_adapter_pkg::unit_count_t'(unit_enabled);
  end

  always_comb begin
    o_csr_mcmd_valid = ready && unit_enabled;
    o_csr_mcmd       = is_ignored ? csr_adapter_pkg::CMD_WRITE_NP : i_mcmd;
    o_csr_maddr      = cur_addr;
    o_csr_mdata      = is_write ?
                       i_mdata[csr_adapter_pkg::UNIT_WIDTH*cur_index +: csr_adapter_pkg::UNIT_WIDTH] :
                       '0;
    o_mcmd_accept    = advance && last_unit;
    o_mdata_accept   = advance && is_write && (last_unit || (cur_index == '1));
  end

  always_comb begin
    o_info_push = o_mcmd_accept && is_non_posted;
    o_info_data = '0;
    o_info_data[csr_adapter_pkg::INFO_IS_READ_BIT] = !is_write;
    o_info_data[csr_adapter_pkg::INFO_IGNORE_BIT]  = is_ignored;
    o_info_data[csr_adapter_pkg::INFO_ID_LSB +: $bits(csr_adapter_pkg::id_t)] = i_mid;
    o_info_data[csr_adapter_pkg::INFO_START_LSB +: $bits(csr_adapter_pkg::unit_index_t)] =
      start_index;
    o_info_data[csr_adapter_pkg::INFO_COUNT_LSB +: $bits(csr_adapter_pkg::unit_count_t)] =
      access_count;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy     <= 1'b0;
      force_q  <= 1'b0;
      remain_q <= '0;
      issued_q <= '0;
      index_q  <= '0;
      addr_q   <= '0;
    end else if (advance) begin
      busy     <= !last_unit;
      force_q  <= cur_force;
      remain_q <= cur_remain - csr_adapter_pkg::unit_count_t'(1);
      issued_q <= access_count;
      index_q  <= cur_index + csr_adapter_pkg::unit_index_t'(1);
      addr_q   <= cur_addr + csr_adapter_pkg::addr_t'(csr_adapter_pkg::UNIT_BYTES);
    end
  end

  // A stalled CSR command keeps its fields until the slave takes it
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_csr_mcmd_valid && !i_csr_scmd_accept) |=>
      (o_csr_mcmd_valid && $stable(o_csr_mcmd) && $stable(o_csr_maddr) &&
       $stable(o_csr_mdata)));

endmodule

/* response_info_fifo.sv */
`timescale 1ns/1ps

module response_info_fifo (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_push,
  input  csr_adapter_pkg::resp_info_t i_data,
  input  logic                        i_pop,
  output csr_adapter_pkg::resp_info_t o_data,
  output logic                        o_empty,
  output logic                        o_full
);

  csr_adapter_pkg::resp_info_t            mem [csr_adapter_pkg::MAX_NP_REQUESTS];
  logic [csr_adapter_pkg::NP_PTR_WIDTH-1:0] wr_ptr;
  logic [csr_adapter_pkg::NP_PTR_WIDTH-1:0] rd_ptr;
  logic [csr_adapter_pkg::NP_PTR_WIDTH:0]   count;

  always_comb begin
    o_data  = mem[rd_ptr];
    o_empty = count == '0;
    o_full  = count == (csr_adapter_pkg::NP_PTR_WIDTH+1)'(csr_adapter_pkg::MAX_NP_REQUESTS);
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + i_push - i_pop;
    end
  end

  assert property (@(posedge i_clk) disable iff (!i_rst_n) i_push |-> !o_full);
  assert property (@(posedge i_clk) disable iff (!i_rst_n) i_pop |-> !o_empty);

endmodule

/* tb_membus2csr_adapter.sv */
`timescale 1ns/1ps

module tb_membus2csr_adapter;

  logic                        i_clk;
  logic                        i_rst_n;
  logic                        i_force_np_write;
  logic                        i_mcmd_valid;
  csr_adapter_pkg::cmd_e       i_mcmd;
  csr_adapter_pkg::addr_t      i_maddr;
  csr_adapter_pkg::length_t    i_mlength;
  csr_adapter_pkg::id_t        i_mid;
  logic                        o_mcmd_accept;
  logic                        i_mdata_valid;
  csr_adapter_pkg::beat_data_t i_mdata;
  csr_adapter_pkg::byteen_t    i_mdata_byteen;
  logic                        o_mdata_accept;
  logic                        o_sresp_valid;
  csr_adapter_pkg::id_t        o_sid;
  csr_adapter_pkg::beat_data_t o_sdata;
  logic                        o_serror;
  logic                        o_sresp_last;
  logic                        i_sresp_accept;
  logic                        o_csr_mcmd_valid;
  csr_adapter_pkg::cmd_e       o_csr_mcmd;
  csr_adapter_pkg::addr_t      o_csr_maddr;
  csr_adapter_pkg::unit_data_t o_csr_mdata;
  logic                        i_csr_scmd_accept;
  logic                        i_csr_sresp_valid;
  csr_adapter_pkg::unit_data_t i_csr_sdata;
  logic                        i_csr_serror;
  logic                        o_csr_mresp_accept;

  // Expected response beats with {id, error, last}, and expected CSR commands {cmd, addr, data}
  csr_adapter_pkg::beat_data_t exp_data [$];
  logic [5:0]                  exp_meta [$];
  logic [49:0]                 exp_cmd [$];
  logic [32:0]                 resp_q [$];
  csr_adapter_pkg::unit_data_t mem [64];
  logic                        written [64];
  csr_adapter_pkg::unit_data_t shadow [64];
  logic                        shadow_wr [64];
  csr_adapter_pkg::beat_data_t beats [4];
  csr_adapter_pkg::byteen_t    bes [4];
  integer                      seed = 61877;
  int                          cycles = 0;
  int                          line_count = 0;

  membus2csr_adapter DUT (.*);

  always #5 i_clk = ~i_clk;

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  //////////////////////////////
  // Expected traffic
  //////////////////////////////
  task automatic expect_burst(input int cmd, input csr_adapter_pkg::addr_t addr, input int len,
                              input csr_adapter_pkg::id_t id, input logic frc,
                              input csr_adapter_pkg::beat_data_t first_beat);
    int                          si;
    int                          n;
    int                          slot;
    int                          bi;
    csr_adapter_pkg::addr_t      ua;
    csr_adapter_pkg::beat_data_t acc;
    logic                        err;
    logic                        wr_err;
    logic                        first;
    logic                        np;
    si     = addr[3:2];
    n      = 4 * len - si;
    acc    = '0;
    err    = 1'b0;
    wr_err = 1'b0;
    first  = 1'b1;
    np     = (cmd == 2) || ((cmd == 1) && frc);
    for (int k = 0; k < n; k++) begin
      slot = (si + k) % 4;
      bi   = (si + k) / 4;
      ua   = (addr & 16'hFFFC) + 16'(4 * k);
      if (cmd == 0) begin
        exp_cmd.push_back({2'd0, ua, 32'd0});
        acc[32*slot +: 32] = shadow_wr[ua[7:2]] ? shadow[ua[7:2]] : 32'hDEAD0000 + ua;
        err = err | (ua >= 16'h00F0 && ua <= 16'h00FF);
        // A read beat closes at slot 3 or on the last unit
        if (slot == 3 || k == n - 1) begin
          exp_data.push_back(first ? first_beat : acc);
          exp_meta.push_back({id, err, k == n - 1});
          acc   = '0;
          err   = 1'b0;
          first = 1'b0;
        end
      end else if (bes[bi][4*slot +: 4] != 4'h0) begin
        exp_cmd.push_back({np ? 2'd2 : 2'd1, ua, beats[bi][32*slot +: 32]});
        shadow[ua[7:2]]    = beats[bi][32*slot +: 32];
        shadow_wr[ua[7:2]] = 1'b1;
        wr_err = wr_err | (ua >= 16'h00F0 && ua <= 16'h00FF);
      end
    end
    if (cmd == 2) begin
      exp_data.push_back('0);
      exp_meta.push_back({id, wr_err, 1'b1});
    end
  endtask

  //////////////////////////////
  // CSR slave model
  //////////////////////////////
  always @(posedge i_clk) begin
    logic [49:0] want;
    if (i_rst_n) begin
      if (o_csr_mcmd_valid && i_csr_scmd_accept) begin
        if (exp_cmd.size() == 0) begin
          abort_run("The DUT issued a CSR command that no burst asked for");
        end else begin
          want = exp_cmd.pop_front();
          check_value(o_csr_mcmd, want[49:48], "CSR command type");
          check_value(o_csr_maddr, want[47:32], "CSR address");
          check_value(o_csr_mdata, want[31:0], "CSR write data");
          if (o_csr_mcmd != csr_adapter_pkg::CMD_READ) begin
            mem[o_csr_maddr[7:2]]     = o_csr_mdata;
            written[o_csr_maddr[7:2]] = 1'b1;
          end
          if (o_csr_mcmd != csr_adapter_pkg::CMD_WRITE) begin
            resp_q.push_back({o_csr_maddr >= 16'h00F0 && o_csr_maddr <= 16'h00FF,
                              (o_csr_mcmd != csr_adapter_pkg::CMD_READ) ? 32'd0 :
                              written[o_csr_maddr[7:2]] ? mem[o_csr_maddr[7:2]] :
                              32'hDEAD0000 + o_csr_maddr});
          end
        end
      end
      if (i_csr_sresp_valid && o_csr_mresp_accept) begin
        void'(resp_q.pop_front());
      end
      // A presented response holds until the DUT takes it
      if (!(i_csr_sresp_valid && !o_csr_mresp_accept)) begin
        if (resp_q.size() > 0 && ($random(seed) & 1)) begin
          i_csr_sresp_valid <= 1'b1;
          {i_csr_serror, i_csr_sdata} <= resp_q[0];
        end else begin
          i_csr_sresp_valid <= 1'b0;
        end
      end
      i_csr_scmd_accept <= ($random(seed) & 3) != 0;
    end
  end

  always @(posedge i_clk) begin
    logic [5:0] meta;
    if (i_rst_n) begin
      if (o_sresp_valid && i_sresp_accept) begin
        if (exp_meta.size() == 0) begin
          abort_run("A memory response beat arrived when none was expected");
        end else begin
          meta = exp_meta.pop_front();
          check_value(o_sdata, exp_data.pop_front(), "response data");
          check_value(o_sid, meta[5:2], "response ID");
          check_value(o_serror, meta[1], "response error");
          check_value(o_sresp_last, meta[0], "response last");
        end
      end
      i_sresp_accept <= $random(seed) & 1;
    end
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles > 200 * (line_count + 1)) begin
      abort_run($sformatf("Timeout after %0d cycles with traffic still outstanding", cycles));
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    int          fd;
    int          n;
    int          b;
    logic        done;
    string       line;
    logic [31:0] cmd;
    logic [31:0] addr;
    logic [31:0] len;
    logic [31:0] id;
    logic [31:0] frc;
    logic [31:0] base;
    logic [31:0] be [4];
    logic [31:0] e [4];
    i_clk = 0;
    i_rst_n = 0;
    i_force_np_write = 0;
    i_mcmd_valid = 0;
    i_mcmd = csr_adapter_pkg::CMD_READ;
    i_maddr = '0;
    i_mlength = '0;
    i_mid = '0;
    i_mdata_valid = 0;
    i_mdata = '0;
    i_mdata_byteen = '0;
    i_sresp_accept = 0;
    i_csr_scmd_accept = 0;
    i_csr_sresp_valid = 0;
    i_csr_sdata = '0;
    i_csr_serror = 0;
    for (int i = 0; i < 64; i++) begin
      written[i]   = 1'b0;
      shadow_wr[i] = 1'b0;
    end
    fd = $fopen("adapter_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the pattern file adapter_patterns.txt");
    end
    repeat (5) @(posedge i_clk);
    i_rst_n <= 1'b1;
    while ($fgets(line, fd)) begin
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", cmd, addr, len, id,
                    frc, base, be[0], be[1], be[2], be[3], e[0], e[1], e[2], e[3]);
        if (n != 14) begin
          abort_run("A pattern line does not hold 14 fields");
        end
        line_count++;
        for (int bb = 0; bb < 4; bb++) begin
          bes[bb] = be[bb][15:0];
          for (int s = 0; s < 4; s++) begin
            beats[bb][32*s +: 32] = base + 32'(4 * bb + s);
          end
        end
        expect_burst(cmd, addr[15:0], len, id[3:0], frc[0], {e[3], e[2], e[1], e[0]});
        @(posedge i_clk);
        i_mcmd_valid     <= 1'b1;
        i_mcmd           <= csr_adapter_pkg::cmd_e'(cmd[1:0]);
        i_maddr          <= addr[15:0];
        i_mlength        <= len[2:0];
        i_mid            <= id[3:0];
        i_force_np_write <= frc[0];
        i_mdata_valid    <= cmd != 0;
        i_mdata          <= beats[0];
        i_mdata_byteen   <= bes[0];
        b    = 0;
        done = 1'b0;
        while (!done) begin
          @(posedge i_clk);
          if (o_mdata_accept && b < 3) begin
            b++;
            i_mdata        <= beats[b];
            i_mdata_byteen <= bes[b];
          end
          if (o_mcmd_accept) begin
            done = 1'b1;
            i_mcmd_valid  <= 1'b0;
            i_mdata_valid <= 1'b0;
          end
        end
      end
    end
    while (exp_meta.size() != 0 || exp_cmd.size() != 0 || resp_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (20) @(posedge i_clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
